// ==== logic/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

	localparam int xlen = 32;

	// numeric codes are what the stimulus file carries
	typedef enum logic [5:0] {
		op_add = 6'h00, op_sub, op_sll, op_slt, op_sltu,
		op_xor, op_srl, op_sra, op_or, op_and,                  // 0x00..0x09
		op_addi = 6'h10, op_slti, op_sltiu, op_xori, op_ori,
		op_andi, op_slli, op_srli, op_srai,                     // 0x10..0x18
		op_lb = 6'h20, op_lh, op_lw, op_lbu, op_lhu,            // 0x20..0x24
		op_sb = 6'h28, op_sh, op_sw,                            // 0x28..0x2a
		op_beq = 6'h30, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		op_jal = 6'h38, op_jalr,
		op_lui = 6'h3c, op_auipc
	} exec_op_e;

	// funct3 in the low bits, bit 3 picks sub / sra
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000,
		alu_sra  = 4'b1101
	} alu_fn_e;

	typedef enum logic [1:0] {
		sz_byte = 2'd0,
		sz_half = 2'd1,
		sz_word = 2'd2
	} mem_size_e;

	typedef struct packed {
		exec_op_e         op;
		logic [xlen-1:0]  rs1;
		logic [xlen-1:0]  rs2;
		logic [xlen-1:0]  imm;  // sign-extended, u-type already shifted
		logic [xlen-1:0]  pc;
	} issue_t;

	typedef struct packed {
		logic             valid;
		logic [xlen-1:0]  data;
	} rf_write_t;

	typedef struct packed {
		logic             valid;
		logic [xlen-1:0]  target;
	} redirect_t;

	typedef struct packed {
		logic [xlen-1:0]  addr;  // byte address
		logic             is_store;
		mem_size_e        size;
		logic             is_unsigned;
		logic [xlen-1:0]  wdata;
	} mem_req_t;

endpackage

`default_nettype wire

// ==== logic/int_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_alu import exec_pkg::*; (
	input  alu_fn_e          fn,
	input  logic [xlen-1:0]  a,
	input  logic [xlen-1:0]  b,
	output logic [xlen-1:0]  y
);

	logic [4:0] shamt;

	assign shamt = b[4:0];  // rv32 shifts use five bits

	always_comb begin
		case (fn)
			alu_add:  y = a + b;
			alu_sub:  y = a - b;
			alu_sll:  y = a << shamt;
			alu_slt:  y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: y = {{(xlen-1){1'b0}}, a < b};
			alu_xor:  y = a ^ b;
			alu_srl:  y = a >> shamt;
			alu_sra:  y = $signed(a) >>> shamt;  // keeps sign bit
			alu_or:   y = a | b;
			alu_and:  y = a & b;
			default:  y = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit import exec_pkg::*; (
	input  exec_op_e         op,
	input  logic [xlen-1:0]  rs1,
	input  logic [xlen-1:0]  rs2,
	input  logic [xlen-1:0]  imm,
	input  logic [xlen-1:0]  pc,
	output redirect_t        redirect,
	output logic [xlen-1:0]  link
);

	logic [xlen-1:0] pc_rel;
	logic [xlen-1:0] reg_rel;
	logic            lt_s;
	logic            lt_u;
	logic            eq;

	assign pc_rel  = pc + imm;
	assign reg_rel = rs1 + imm;
	assign link    = pc + xlen'(4);

	assign eq   = rs1 == rs2;
	assign lt_s = $signed(rs1) < $signed(rs2);
	assign lt_u = rs1 < rs2;

	always_comb begin
		redirect.target = pc_rel;
		case (op)
			op_beq:  redirect.valid = eq;
			op_bne:  redirect.valid = !eq;
			op_blt:  redirect.valid = lt_s;
			op_bge:  redirect.valid = !lt_s;
			op_bltu: redirect.valid = lt_u;
			op_bgeu: redirect.valid = !lt_u;
			op_jal:  redirect.valid = 1'b1;
			op_jalr: begin
				redirect.valid  = 1'b1;
				redirect.target = {reg_rel[xlen-1:1], 1'b0};  // lsb forced low
			end
			default: redirect.valid = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import exec_pkg::*; #(
	parameter int addr_w = 16
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  mem_req_t           req,
	output logic               done,
	output logic [xlen-1:0]    load_data,
	output logic               cyc,
	output logic               stb,
	output logic               we,
	output logic [addr_w-1:0]  adr,
	output logic [3:0]         sel,
	output logic [xlen-1:0]    dat_o,
	input  logic [xlen-1:0]    dat_i,
	input  logic               ack
);

	mem_req_t        req_q;
	logic [1:0]      lane;
	logic [xlen-1:0] rd_shift;
	logic [xlen-1:0] ld_ext;
	logic            ack_seen;

	assign lane     = req_q.addr[1:0];
	assign ack_seen = cyc & ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cyc  <= 1'b0;
			we   <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= ack_seen;
			if (ack_seen) begin
				cyc <= 1'b0;
				we  <= 1'b0;
			end else if (start) begin
				cyc <= 1'b1;
				we  <= req.is_store;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !cyc)
			req_q <= req;
		if (ack_seen)
			load_data <= ld_ext;
	end

	assign stb = cyc;  // classic, single beat
	assign adr = addr_w'(req_q.addr[xlen-1:2]);

	// lanes and store data placement
	always_comb begin
		dat_o = req_q.wdata << {lane, 3'b000};
		case (req_q.size)
			sz_byte: sel = 4'b0001 << lane;
			sz_half: sel = 4'b0011 << lane;
			default: sel = 4'b1111;
		endcase
	end

	// move the addressed lane down, then extend
	assign rd_shift = dat_i >> {lane, 3'b000};

	always_comb begin
		case (req_q.size)
			sz_byte: begin
				if (req_q.is_unsigned)
					ld_ext = {{(xlen-8){1'b0}}, rd_shift[7:0]};
				else
					ld_ext = {{(xlen-8){rd_shift[7]}}, rd_shift[7:0]};
			end
			sz_half: begin
				if (req_q.is_unsigned)
					ld_ext = {{(xlen-16){1'b0}}, rd_shift[15:0]};
				else
					ld_ext = {{(xlen-16){rd_shift[15]}}, rd_shift[15:0]};
			end
			default: ld_ext = dat_i;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit import exec_pkg::*; #(
	parameter int addr_w = 16
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue_valid,
	input  issue_t             issue,
	output logic               ready,
	output rf_write_t          rf_write,
	output redirect_t          redirect,
	output logic               cyc,
	output logic               stb,
	output logic               we,
	output logic [addr_w-1:0]  adr,
	output logic [3:0]         sel,
	output logic [xlen-1:0]    dat_o,
	input  logic [xlen-1:0]    dat_i,
	input  logic               ack
);

	logic            issue_vld_q;
	issue_t          issue_q;
	logic            is_load;
	logic            is_store;
	logic            is_branch;
	logic            is_jump;
	logic            writes_rd;
	alu_fn_e         alu_fn;
	logic [xlen-1:0] alu_a;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_y;
	logic [xlen-1:0] link;
	redirect_t       br_redirect;
	mem_req_t        mem_req;
	logic            mem_start;
	logic            mem_done;
	logic [xlen-1:0] load_data;
	logic            ld_pend_q;
	logic            ld_wb;
	logic            rf_vld_q;
	logic [xlen-1:0] rf_data_q;
	logic            redir_vld_q;
	logic [xlen-1:0] redir_tgt_q;

	// memory op holds the stage from issue until ack
	assign ready = ~(mem_start | cyc);

	always_ff @(posedge clk) begin
		if (!rst_n)
			issue_vld_q <= 1'b0;
		else
			issue_vld_q <= issue_valid & ready;
	end

	always_ff @(posedge clk) begin
		if (issue_valid && ready)
			issue_q <= issue;
	end

	assign is_load   = issue_q.op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
	assign is_store  = issue_q.op inside {op_sb, op_sh, op_sw};
	assign is_branch = issue_q.op inside {[op_beq:op_bgeu]};
	assign is_jump   = issue_q.op inside {op_jal, op_jalr};
	assign writes_rd = !(is_load || is_store || is_branch);
	assign mem_start = issue_vld_q & (is_load | is_store);

	always_comb begin
		case (issue_q.op)
			op_sub:           alu_fn = alu_sub;
			op_sll, op_slli:  alu_fn = alu_sll;
			op_slt, op_slti:  alu_fn = alu_slt;
			op_sltu, op_sltiu: alu_fn = alu_sltu;
			op_xor, op_xori:  alu_fn = alu_xor;
			op_srl, op_srli:  alu_fn = alu_srl;
			op_sra, op_srai:  alu_fn = alu_sra;
			op_or, op_ori:    alu_fn = alu_or;
			op_and, op_andi:  alu_fn = alu_and;
			default:          alu_fn = alu_add;  // also addresses, lui, auipc
		endcase
	end

	always_comb begin
		alu_a = issue_q.rs1;
		alu_b = issue_q.imm;
		if (issue_q.op inside {[op_add:op_and]})
			alu_b = issue_q.rs2;
		if (issue_q.op == op_lui)
			alu_a = '0;
		else if (issue_q.op == op_auipc)
			alu_a = issue_q.pc;
	end

	int_alu alu_i (
		.fn (alu_fn),
		.a  (alu_a),
		.b  (alu_b),
		.y  (alu_y)
	);

	branch_unit br_i (
		.op       (issue_q.op),
		.rs1      (issue_q.rs1),
		.rs2      (issue_q.rs2),
		.imm      (issue_q.imm),
		.pc       (issue_q.pc),
		.redirect (br_redirect),
		.link     (link)
	);

	always_comb begin
		mem_req.addr        = alu_y;  // rs1 + imm
		mem_req.is_store    = is_store;
		mem_req.is_unsigned = issue_q.op inside {op_lbu, op_lhu};
		mem_req.wdata       = issue_q.rs2;
		case (issue_q.op)
			op_lb, op_lbu, op_sb: mem_req.size = sz_byte;
			op_lh, op_lhu, op_sh: mem_req.size = sz_half;
			default:              mem_req.size = sz_word;
		endcase
	end

	load_store_unit #(
		.addr_w (addr_w)
	) lsu_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (mem_start),
		.req       (mem_req),
		.done      (mem_done),
		.load_data (load_data),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.sel       (sel),
		.dat_o     (dat_o),
		.dat_i     (dat_i),
		.ack       (ack)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rf_vld_q    <= 1'b0;
			redir_vld_q <= 1'b0;
			ld_pend_q   <= 1'b0;
		end else begin
			rf_vld_q    <= issue_vld_q & writes_rd;
			redir_vld_q <= issue_vld_q & br_redirect.valid;
			if (mem_start)
				ld_pend_q <= is_load;
			else if (mem_done)
				ld_pend_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		rf_data_q   <= is_jump ? link : alu_y;
		redir_tgt_q <= br_redirect.target;
	end

	// load data bypasses the result register
	assign ld_wb           = mem_done & ld_pend_q;
	assign rf_write.valid  = rf_vld_q | ld_wb;
	assign rf_write.data   = ld_wb ? load_data : rf_data_q;
	assign redirect.valid  = redir_vld_q;
	assign redirect.target = redir_tgt_q;

endmodule

`default_nettype wire

// ==== bench/exec_unit_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_chk import exec_pkg::*; #(
	parameter int addr_w = 16
) (
	input logic              clk,
	input logic              rst_n,
	input logic              cyc,
	input logic              stb,
	input logic              we,
	input logic              ack,
	input logic              ready,
	input logic              rf_valid,
	input logic [addr_w-1:0] adr,
	input logic [3:0]        sel,
	input logic [xlen-1:0]   dat_o
);

	int unsigned stb_fails   = 0;
	int unsigned hold_fails  = 0;
	int unsigned ready_fails = 0;
	int unsigned pulse_fails = 0;

	assert property (@(posedge clk) disable iff (!rst_n) stb |-> cyc)
		else begin
			stb_fails++;
			$error("stb high without cyc");
		end

	// request held through wait states
	assert property (@(posedge clk) disable iff (!rst_n)
		cyc && !ack |=> cyc && stb && $stable(adr) && $stable(sel) && $stable(we)
			&& $stable(dat_o))
		else begin
			hold_fails++;
			$error("wishbone request changed before ack");
		end

	assert property (@(posedge clk) disable iff (!rst_n) cyc |-> !ready)
		else begin
			ready_fails++;
			$error("ready high during a wishbone cycle");
		end

	assert property (@(posedge clk) disable iff (!rst_n) rf_valid |=> !rf_valid)
		else begin
			pulse_fails++;
			$error("rf_write valid longer than one cycle");
		end

endmodule

bind exec_unit exec_unit_chk #(
	.addr_w (addr_w)
) chk_i (
	.clk      (clk),
	.rst_n    (rst_n),
	.cyc      (cyc),
	.stb      (stb),
	.we       (we),
	.ack      (ack),
	.ready    (ready),
	.rf_valid (rf_write.valid),
	.adr      (adr),
	.sel      (sel),
	.dat_o    (dat_o)
);

`default_nettype wire

// ==== bench/tb_exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit import exec_pkg::*; ();

	localparam int addr_w  = 16;
	localparam int timeout = 100;  // cycles per wait

	logic              clk;
	logic              rst_n;
	logic              issue_valid;
	issue_t            issue;
	logic              ready;
	rf_write_t         rf_write;
	redirect_t         redirect;
	logic              cyc;
	logic              stb;
	logic              we;
	logic [addr_w-1:0] adr;
	logic [3:0]        sel;
	logic [31:0]       dat_o;
	logic [31:0]       dat_i;
	logic              ack;
	logic [31:0]       mem [0:(1 << addr_w)-1];
	int                errors;
	int                checks;
	int                lines;
	int unsigned       ack_count;
	bit                timed_out;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	exec_unit #(
		.addr_w (addr_w)
	) dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue       (issue),
		.ready       (ready),
		.rf_write    (rf_write),
		.redirect    (redirect),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.adr         (adr),
		.sel         (sel),
		.dat_o       (dat_o),
		.dat_i       (dat_i),
		.ack         (ack)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("Timed out after %0d cycles waiting for %s at %0t", timeout, what, $time);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// wishbone slave, 0..3 wait states per access
	initial begin
		int unsigned wait_left;
		bit          pending;
		logic [31:0] wmask;
		ack       = 1'b0;
		dat_i     = '0;
		pending   = 1'b0;
		wait_left = 0;
		ack_count = 0;
		for (int i = 0; i < (1 << addr_w); i++)
			mem[addr_w'(i)] = '0;
		forever begin
			next_cycle();
			if (ack) begin
				ack = 1'b0;  // seen by the master at the last edge
			end else if (cyc && stb) begin
				if (!pending) begin
					pending   = 1'b1;
					wait_left = $urandom_range(3, 0);
				end
				if (wait_left == 0) begin
					wmask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
					if (we)
						mem[adr] = (mem[adr] & ~wmask) | (dat_o & wmask);
					else
						dat_i = mem[adr];
					ack     = 1'b1;
					pending = 1'b0;
					ack_count++;
				end else begin
					wait_left--;
				end
			end
		end
	end

	task automatic execute_line(input logic [5:0] op_code, input logic [31:0] rs1,
			input logic [31:0] rs2, input logic [31:0] imm, input logic [31:0] pc,
			input int kind, input logic [31:0] expected, input int redir,
			input logic [31:0] target);
		int          cycles;
		bit          is_mem;
		bit          finished;
		int unsigned acks_before;
		logic [31:0] addr;
		is_mem = op_code[5:4] == 2'b10;  // loads 0x20.., stores 0x28..
		cycles = 0;
		while (!ready && cycles < timeout) begin
			next_cycle();
			cycles++;
		end
		if (!ready) begin
			report_timeout("ready before issue");
			return;
		end
		issue.op    = exec_op_e'(op_code);
		issue.rs1   = rs1;
		issue.rs2   = rs2;
		issue.imm   = imm;
		issue.pc    = pc;
		issue_valid = 1'b1;
		acks_before = ack_count;
		next_cycle();  // accepted on this edge
		issue_valid = 1'b0;
		if (!is_mem) begin
			next_cycle();  // result one cycle after acceptance
			check_value("rf_write.valid", 32'(kind == 1), 32'(rf_write.valid));
			if (kind == 1)
				check_value("rf_write.data", expected, rf_write.data);
			check_value("redirect.valid", 32'(redir != 0), 32'(redirect.valid));
			if (redir != 0)
				check_value("redirect.target", target, redirect.target);
			return;
		end
		cycles   = 0;
		finished = 1'b0;
		while (!finished && cycles < timeout) begin
			if (kind == 1)
				finished = rf_write.valid;
			else
				finished = (ack_count != acks_before) && !cyc;  // store ends when its cycle closes
			if (!finished) begin
				check_value("ready", 32'd0, 32'(ready));  // held low during access
				next_cycle();
				cycles++;
			end
		end
		if (!finished) begin
			report_timeout("memory access to complete");
			return;
		end
		check_value("ready", 32'd1, 32'(ready));
		check_value("redirect.valid", 32'd0, 32'(redirect.valid));
		check_value("wishbone cycles", 32'd1, ack_count - acks_before);
		if (kind == 1) begin
			check_value("rf_write.data", expected, rf_write.data);
		end else begin
			addr = rs1 + imm;
			check_value("rf_write.valid", 32'd0, 32'(rf_write.valid));
			check_value("memory word", expected, mem[addr[addr_w+1:2]]);
		end
	endtask

	initial begin
		int          fd;
		int          n;
		int          kind;
		int          redir;
		string       line;
		logic [31:0] op_code;
		logic [31:0] rs1;
		logic [31:0] rs2;
		logic [31:0] imm;
		logic [31:0] pc;
		logic [31:0] expected;
		logic [31:0] target;
		void'($urandom(32'h934b_257c));
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		errors      = 0;
		checks      = 0;
		lines       = 0;
		timed_out   = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		next_cycle();
		check_value("rf_write.valid", 32'd0, 32'(rf_write.valid));
		check_value("redirect.valid", 32'd0, 32'(redirect.valid));
		check_value("cyc", 32'd0, 32'(cyc));
		check_value("ready", 32'd1, 32'(ready));
		fd = $fopen("bench/exec_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the stimulus file bench/exec_stimulus.txt");
		end else begin
			while (!timed_out && $fgets(line, fd) != 0) begin
				if (line.len() == 0 || line[0] == "#")
					continue;
				n = $sscanf(line, "%h %h %h %h %h %d %h %d %h", op_code, rs1, rs2, imm, pc,
					kind, expected, redir, target);
				if (n != 9)
					continue;  // blank line
				lines++;
				execute_line(op_code[5:0], rs1, rs2, imm, pc, kind, expected, redir, target);
			end
			$fclose(fd);
			if (lines == 0) begin
				errors++;
				$display("The stimulus file held no instructions");
			end
		end
		errors += dut_i.chk_i.stb_fails + dut_i.chk_i.hold_fails;
		errors += dut_i.chk_i.ready_fails + dut_i.chk_i.pulse_fails;
		$display("Instructions: %0d, checks: %0d, errors: %0d", lines, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/exec_stimulus.txt ====
# op rs1 rs2 imm pc kind expected redirect target (hex, kind and redirect decimal)
# kind: 0 no register write, 1 check rd value, 2 check memory word after a store
00 00000005 00000007 00000000 00000000 1 0000000c 0 00000000
01 00000005 00000007 00000000 00000000 1 fffffffe 0 00000000
02 00000003 00000024 00000000 00000000 1 00000030 0 00000000
03 fffffffe 00000001 00000000 00000000 1 00000001 0 00000000
04 fffffffe 00000001 00000000 00000000 1 00000000 0 00000000
05 0f0f0f0f 00ff00ff 00000000 00000000 1 0ff00ff0 0 00000000
06 80000000 00000004 00000000 00000000 1 08000000 0 00000000
07 80000010 00000004 00000000 00000000 1 f8000001 0 00000000
08 12340000 00005678 00000000 00000000 1 12345678 0 00000000
09 ff00ff00 0ff00ff0 00000000 00000000 1 0f000f00 0 00000000
10 00000010 00000000 fffffff0 00000000 1 00000000 0 00000000
11 00000005 00000000 fffffffb 00000000 1 00000000 0 00000000
12 00000005 00000000 fffffffb 00000000 1 00000001 0 00000000
13 00000055 00000000 ffffffff 00000000 1 ffffffaa 0 00000000
14 00000100 00000000 0000000f 00000000 1 0000010f 0 00000000
15 abcd1234 00000000 000000ff 00000000 1 00000034 0 00000000
16 00000001 00000000 0000001f 00000000 1 80000000 0 00000000
17 f0000000 00000000 0000001c 00000000 1 0000000f 0 00000000
18 f0000000 00000000 0000001c 00000000 1 ffffffff 0 00000000
3c 00000000 00000000 12345000 00000000 1 12345000 0 00000000
3d 00000000 00000000 00001000 00000100 1 00001100 0 00000000
30 00000005 00000005 00000010 00000200 0 00000000 1 00000210
30 00000005 00000006 00000010 00000200 0 00000000 0 00000000
31 00000005 00000006 00000010 00000200 0 00000000 1 00000210
32 ffffffff 00000001 00000010 00000200 0 00000000 1 00000210
33 ffffffff 00000001 00000010 00000200 0 00000000 0 00000000
34 ffffffff 00000001 00000010 00000200 0 00000000 0 00000000
35 ffffffff 00000001 00000010 00000200 0 00000000 1 00000210
38 00000000 00000000 fffffff0 00000200 1 00000204 1 000001f0
39 00001001 00000000 00000004 00000300 1 00000304 1 00001004
2a 00000100 11223344 00000000 00000000 2 11223344 0 00000000
28 00000100 000000aa 00000001 00000000 2 1122aa44 0 00000000
29 00000100 0000beef 00000002 00000000 2 beefaa44 0 00000000
28 00000100 00000080 00000000 00000000 2 beefaa80 0 00000000
2a 00000110 cafef00d fffffffc 00000000 2 cafef00d 0 00000000
22 00000100 00000000 00000000 00000000 1 beefaa80 0 00000000
20 00000100 00000000 00000000 00000000 1 ffffff80 0 00000000
23 00000100 00000000 00000000 00000000 1 00000080 0 00000000
20 00000100 00000000 00000001 00000000 1 ffffffaa 0 00000000
20 00000100 00000000 00000002 00000000 1 ffffffef 0 00000000
23 00000100 00000000 00000003 00000000 1 000000be 0 00000000
21 00000100 00000000 00000002 00000000 1 ffffbeef 0 00000000
24 00000100 00000000 00000002 00000000 1 0000beef 0 00000000
21 00000100 00000000 00000000 00000000 1 ffffaa80 0 00000000
24 0000010c 00000000 00000000 00000000 1 0000f00d 0 00000000
22 00000100 00000000 00000000 00000000 1 beefaa80 0 00000000
22 00000100 00000000 00000000 00000000 1 beefaa80 0 00000000

// ==== list.f ====
logic/exec_pkg.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/load_store_unit.sv
logic/exec_unit.sv
bench/exec_unit_chk.sv
bench/tb_exec_unit.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_exec_unit
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
